/* design/kbd_params.svh */
`ifndef KBD_PARAMS_SVH
`define KBD_PARAMS_SVH

// Receiver queue depth.
// Any power of two works, since the pointers carry one extra wrap bit.
`define KBD_FIFO_DEPTH 8

// Flip-flops on each PS/2 line before edge detection.
`define KBD_SYNC_STAGES 3

// Segment patterns are active low, with bit 7 as the decimal point.
`define KBD_SEG_BLANK 8'hFF

// Set-2 prefix sent before the code of a released key.
`define KBD_BREAK_CODE 8'hF0

`endif

/* design/kbd_pkg.sv */
package kbd_pkg;

    // One byte off the keyboard, or its ASCII value.
    typedef logic [7:0] scan_code_t;

    // Four active-low digit patterns, left to right as driven by the top level.
    typedef struct packed {
        logic [7:0] hex_lo;   // Low nibble of the held key.
        logic [7:0] hex_hi;   // High nibble of the held key.
        logic [7:0] dec_tens; // ASCII value, tens digit.
        logic [7:0] dec_ones; // ASCII value, ones digit.
    } disp_t;

endpackage

/* design/ps2_receiver.sv */
`timescale 1ns/1ns
`include "kbd_params.svh"

module ps2_receiver
    import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    input  logic       next_n,
    output scan_code_t data,
    output logic       ready,
    output logic       overflow
);

    localparam int DEPTH = `KBD_FIFO_DEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int SYNC  = `KBD_SYNC_STAGES;

    logic [SYNC-1:0] clk_sync;
    logic [SYNC-1:0] dat_sync;
    logic            clk_last;
    logic            clk_fall;
    logic [3:0]      bit_cnt;
    logic [9:0]      shift;
    logic            frame_done;
    logic            frame_ok;
    logic            push;
    logic            pop;
    logic            full;
    logic [AW:0]     wr_ptr;
    logic [AW:0]     rd_ptr;
    scan_code_t      mem [DEPTH];

    // Both lines idle high.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;
            dat_sync <= '1;
            clk_last <= 1'b1;
        end
        else
        begin
            clk_sync <= {clk_sync[SYNC-2:0], ps2_clk};
            dat_sync <= {dat_sync[SYNC-2:0], ps2_dat};
            clk_last <= clk_sync[SYNC-1];
        end
    end

    assign clk_fall = clk_last & ~clk_sync[SYNC-1];

    // Counts start, eight data bits and parity, then the stop bit closes the frame.
    always_ff @(posedge clk)
    begin
        if (!rst)
            bit_cnt <= '0;
        else if (clk_fall)
        begin
            if (bit_cnt == 4'd10)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 4'd1;
        end
    end

    // LSB first; after ten bits shift[0] is the start bit.
    always_ff @(posedge clk)
    begin
        if (clk_fall)
            shift <= {dat_sync[SYNC-1], shift[9:1]};
    end

    assign frame_done = clk_fall && (bit_cnt == 4'd10);
    assign frame_ok   = !shift[0] && dat_sync[SYNC-1] && (^shift[9:1]); // Odd parity.

    assign push  = frame_done && frame_ok && !full;
    assign ready = (wr_ptr != rd_ptr);
    assign pop   = ready && !next_n;
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign data  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr[AW-1:0]] <= shift[8:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            // A good frame with nowhere to go is lost.
            if (frame_done && frame_ok && full)
                overflow <= 1'b1;
            else if (pop)
                overflow <= 1'b0;
        end
    end

endmodule

/* design/key_tracker.sv */
`timescale 1ns/1ns
`include "kbd_params.svh"

module key_tracker
    import kbd_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  scan_code_t data,
    input  logic       ready,
    input  logic       overflow,
    output logic       next_n,
    output scan_code_t key_code,
    output logic       hex_blank
);

    typedef enum logic [2:0] {
        IDLE,
        POP_MAKE,
        POP_BRK,
        WAIT_REL,
        POP_REL,
        DRAIN
    } state_t;

    state_t state;

    // next_n is low for exactly the one cycle spent in a POP or DRAIN state.
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state     <= IDLE;
            next_n    <= 1'b1;
            key_code  <= '0;
            hex_blank <= 1'b1;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (ready)
                    begin
                        next_n <= 1'b0;
                        if (overflow)
                            state <= DRAIN;
                        else if (data == `KBD_BREAK_CODE)
                            state <= POP_BRK;
                        else
                            state <= POP_MAKE;
                    end
                end
                POP_MAKE:
                begin
                    next_n    <= 1'b1;
                    key_code  <= data; // Still valid until the pop edge.
                    hex_blank <= 1'b0;
                    state     <= IDLE;
                end
                POP_BRK:
                begin
                    next_n <= 1'b1;
                    state  <= WAIT_REL;
                end
                WAIT_REL:
                begin
                    // Code of the released key follows F0.
                    if (ready)
                    begin
                        next_n <= 1'b0;
                        state  <= overflow ? DRAIN : POP_REL;
                    end
                end
                POP_REL:
                begin
                    next_n    <= 1'b1;
                    hex_blank <= 1'b1;
                    state     <= IDLE;
                end
                DRAIN:
                begin
                    next_n <= 1'b1;
                    state  <= IDLE;
                end
                default:
                begin
                    next_n <= 1'b1;
                    state  <= IDLE;
                end
            endcase
        end
    end

endmodule

/* design/scan_ascii_rom.sv */
`timescale 1ns/1ns

module scan_ascii_rom
    import kbd_pkg::*;
(
    input  logic       clk,
    input  scan_code_t addr,
    output scan_code_t ascii
);

    // Set-2 make codes for letters and the top-row digits.
    always_ff @(posedge clk)
    begin
        case (addr)
            8'h1C: ascii <= 8'd65;  // A
            8'h32: ascii <= 8'd66;
            8'h21: ascii <= 8'd67;
            8'h23: ascii <= 8'd68;
            8'h24: ascii <= 8'd69;
            8'h2B: ascii <= 8'd70;
            8'h34: ascii <= 8'd71;
            8'h33: ascii <= 8'd72;
            8'h43: ascii <= 8'd73;
            8'h3B: ascii <= 8'd74;
            8'h42: ascii <= 8'd75;
            8'h4B: ascii <= 8'd76;
            8'h3A: ascii <= 8'd77;
            8'h31: ascii <= 8'd78;
            8'h44: ascii <= 8'd79;
            8'h4D: ascii <= 8'd80;
            8'h15: ascii <= 8'd81;
            8'h2D: ascii <= 8'd82;
            8'h1B: ascii <= 8'd83;
            8'h2C: ascii <= 8'd84;
            8'h3C: ascii <= 8'd85;
            8'h2A: ascii <= 8'd86;
            8'h1D: ascii <= 8'd87;
            8'h22: ascii <= 8'd88;
            8'h35: ascii <= 8'd89;
            8'h1A: ascii <= 8'd90;  // Z
            8'h45: ascii <= 8'd48;  // 0
            8'h16: ascii <= 8'd49;
            8'h1E: ascii <= 8'd50;
            8'h26: ascii <= 8'd51;
            8'h25: ascii <= 8'd52;
            8'h2E: ascii <= 8'd53;
            8'h36: ascii <= 8'd54;
            8'h3D: ascii <= 8'd55;
            8'h3E: ascii <= 8'd56;
            8'h46: ascii <= 8'd57;  // 9
            default: ascii <= 8'd0;
        endcase
    end

endmodule

/* design/seg7_decoder.sv */
`timescale 1ns/1ns
`include "kbd_params.svh"

module seg7_decoder
(
    input  logic [3:0] num,
    input  logic       blank,
    output logic [7:0] seg
);

    // Active low, bit 7 is the decimal point and stays dark.
    always_comb
    begin
        if (blank)
            seg = `KBD_SEG_BLANK;
        else
        begin
            case (num)
                4'h0: seg = 8'hC0;
                4'h1: seg = 8'hF9;
                4'h2: seg = 8'hA4;
                4'h3: seg = 8'hB0;
                4'h4: seg = 8'h99;
                4'h5: seg = 8'h92;
                4'h6: seg = 8'h82;
                4'h7: seg = 8'hF8;
                4'h8: seg = 8'h80;
                4'h9: seg = 8'h90;
                4'hA: seg = 8'h88;
                4'hB: seg = 8'h83; // Lower case b.
                4'hC: seg = 8'hC6;
                4'hD: seg = 8'hA1; // Lower case d.
                4'hE: seg = 8'h86;
                default: seg = 8'h8E;
            endcase
        end
    end

endmodule

/* design/kbd_display_top.sv */
`timescale 1ns/1ns

module kbd_display_top
    import kbd_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  ps2_clk,
    input  logic  ps2_dat,
    output disp_t disp
);

    scan_code_t rx_data;
    scan_code_t key_code;
    scan_code_t ascii;
    logic       ready;
    logic       next_n;
    logic       overflow;
    logic       hex_blank;
    logic [7:0] seg_hex_lo;
    logic [7:0] seg_hex_hi;
    logic [7:0] seg_dec_tens;
    logic [7:0] seg_dec_ones;

    ps2_receiver rx_inst (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .next_n   (next_n),
        .data     (rx_data),
        .ready    (ready),
        .overflow (overflow)
    );

    key_tracker tracker_inst (
        .clk       (clk),
        .rst       (rst),
        .data      (rx_data),
        .ready     (ready),
        .overflow  (overflow),
        .next_n    (next_n),
        .key_code  (key_code),
        .hex_blank (hex_blank)
    );

    scan_ascii_rom rom_inst (
        .clk   (clk),
        .addr  (key_code),
        .ascii (ascii)
    );

    seg7_decoder hex_lo_inst (
        .num   (4'(key_code % 8'd16)),
        .blank (hex_blank),
        .seg   (seg_hex_lo)
    );

    seg7_decoder hex_hi_inst (
        .num   (4'(key_code / 8'd16)),
        .blank (hex_blank),
        .seg   (seg_hex_hi)
    );

    // ASCII of mapped keys never exceeds 90, so the tens fit a nibble.
    seg7_decoder dec_tens_inst (
        .num   (4'(ascii / 8'd10)),
        .blank (1'b0),
        .seg   (seg_dec_tens)
    );

    seg7_decoder dec_ones_inst (
        .num   (4'(ascii % 8'd10)),
        .blank (1'b0),
        .seg   (seg_dec_ones)
    );

    assign disp = '{
        hex_lo:   seg_hex_lo,
        hex_hi:   seg_hex_hi,
        dec_tens: seg_dec_tens,
        dec_ones: seg_dec_ones
    };

endmodule

/* bench/kbd_display_tb.sv */
`timescale 1ns/1ns
`include "kbd_params.svh"

module kbd_display_tb
    import kbd_pkg::*;
;

    localparam int CLK_PERIOD      = 20;
    localparam int PS2_HALF        = 10;  // Clk cycles per ps2_clk half period.
    localparam int SETTLE_CYCLES   = 12;
    localparam int NUM_ROWS        = 7;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 250 + 1000;

    // Set-2 make codes, A to Z and 0 to 9.
    localparam scan_code_t LETTER_CODES [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
        8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
        8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    localparam scan_code_t DIGIT_CODES [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };

    typedef struct packed {
        scan_code_t code;
        logic       bad_parity;
        disp_t      want;
    } row_t;

    logic  clk;
    logic  rst;
    logic  ps2_clk;
    logic  ps2_dat;
    disp_t disp;
    row_t  rows [NUM_ROWS];

    kbd_display_top dut (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .disp    (disp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic scan_code_t ascii_of(input scan_code_t code);
        scan_code_t result;
        result = 8'd0;
        for (int i = 0; i < 26; i++)
        begin
            if (LETTER_CODES[i] == code)
                result = 8'(65 + i);
        end
        for (int i = 0; i < 10; i++)
        begin
            if (DIGIT_CODES[i] == code)
                result = 8'(48 + i);
        end
        return result;
    endfunction

    // Active-low pattern with the decimal point dark.
    function automatic logic [7:0] seg_of(input logic [3:0] d);
        logic [7:0] s;
        case (d)
            4'h0: s = 8'hC0;
            4'h1: s = 8'hF9;
            4'h2: s = 8'hA4;
            4'h3: s = 8'hB0;
            4'h4: s = 8'h99;
            4'h5: s = 8'h92;
            4'h6: s = 8'h82;
            4'h7: s = 8'hF8;
            4'h8: s = 8'h80;
            4'h9: s = 8'h90;
            4'hA: s = 8'h88;
            4'hB: s = 8'h83;
            4'hC: s = 8'hC6;
            4'hD: s = 8'hA1;
            4'hE: s = 8'h86;
            default: s = 8'h8E;
        endcase
        return s;
    endfunction

    function automatic disp_t expect_disp(input scan_code_t shown, input logic blank,
                                          input scan_code_t last_make);
        disp_t      d;
        scan_code_t a;
        a          = ascii_of(last_make);
        d.hex_lo   = blank ? `KBD_SEG_BLANK : seg_of(shown[3:0]);
        d.hex_hi   = blank ? `KBD_SEG_BLANK : seg_of(shown[7:4]);
        d.dec_tens = seg_of(4'(a / 10));
        d.dec_ones = seg_of(4'(a % 10));
        return d;
    endfunction

    function automatic row_t make_row(input scan_code_t code, input logic bad_parity,
                                      input disp_t want);
        row_t r;
        r.code       = code;
        r.bad_parity = bad_parity;
        r.want       = want;
        return r;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // Start bit, eight data bits LSB first, odd parity, stop bit.
    task automatic send_frame(input scan_code_t code, input logic bad_parity);
        logic [10:0] bits;
        logic        par;
        par  = (~^code) ^ bad_parity;
        bits = {1'b1, par, code, 1'b0};
        for (int i = 0; i < 11; i++)
        begin
            ps2_dat = bits[i];
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
    endtask

    task automatic check_seg(input logic [7:0] got, input logic [7:0] want,
                             input string field, input string label);
        if (got !== want)
        begin
            $display("MISMATCH at %0t ns: %s %s is %h, expected %h",
                     $time, label, field, got, want);
            $display("SOME TESTS FAILED");
            $fatal(1, "Stopped at the first wrong digit.");
        end
    endtask

    task automatic check_disp(input disp_t got, input disp_t want, input string label);
        check_seg(got.hex_lo, want.hex_lo, "hex_lo", label);
        check_seg(got.hex_hi, want.hex_hi, "hex_hi", label);
        check_seg(got.dec_tens, want.dec_tens, "dec_tens", label);
        check_seg(got.dec_ones, want.dec_ones, "dec_ones", label);
    endtask

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish in %0d cycles.",
                 WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1, "Watchdog expired.");
    end

    initial
    begin
        clk     = 1'b0;
        rst     = 1'b0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;

        // Press A, release it, then noise, two queued keys and an unmapped one.
        rows[0] = make_row(8'h1C, 1'b0, expect_disp(8'h1C, 1'b0, 8'h1C));
        rows[1] = make_row(8'hF0, 1'b0, expect_disp(8'h1C, 1'b0, 8'h1C));
        rows[2] = make_row(8'h1C, 1'b0, expect_disp(8'h1C, 1'b1, 8'h1C));
        rows[3] = make_row(8'h16, 1'b1, expect_disp(8'h1C, 1'b1, 8'h1C));
        rows[4] = make_row(8'h16, 1'b0, expect_disp(8'h16, 1'b0, 8'h16));
        rows[5] = make_row(8'h1A, 1'b0, expect_disp(8'h1A, 1'b0, 8'h1A));
        rows[6] = make_row(8'h05, 1'b0, expect_disp(8'h05, 1'b0, 8'h05));

        wait_cycles(4);
        rst = 1'b1;
        wait_cycles(1);

        // Blank hex, decimal reads 00.
        check_disp(disp, expect_disp(8'h00, 1'b1, 8'h00), "after reset");

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            send_frame(rows[r].code, rows[r].bad_parity);
            wait_cycles(SETTLE_CYCLES);
            check_disp(disp, rows[r].want, $sformatf("row %0d", r));
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
design/kbd_pkg.sv
design/ps2_receiver.sv
design/key_tracker.sv
design/scan_ascii_rom.sv
design/seg7_decoder.sv
design/kbd_display_top.sv
bench/kbd_display_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the keyboard display testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
    -f verilog.f --top-module kbd_display_tb -o kbd_sim \
    && ./obj_dir/kbd_sim \
    || { echo "Simulation failed."; exit 1; }
